// ==== boot.hex ====
5a
5b
58
59
5e
5f
5c
5d
52
53
50
51
56
57
54
55
4a
4b
48
49
4e
4f
4c
4d
42
43
40
41
46
47
44
45

// ==== src.f ====
logic/sys_pkg.sv
logic/sync_ram.sv
logic/boot_rom.sv
logic/mem_decoder.sv
logic/bus_arbiter.sv
logic/video_pattern.sv
logic/system.sv
verif/tb_clock.sv
verif/tb_system.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_system -f src.f -o sim

run: compile
	./obj_dir/sim | tee /dev/stderr | grep "All tests passed" > /dev/null

clean:
	rm -rf obj_dir

// ==== verif/tb_system.sv ====
`timescale 1ns/1ps

module tb_system import sys_pkg::*; ();

localparam int TIMEOUT = 200;
localparam int ROUNDS = 6;
localparam int RESET_CYCLES = 8;

logic clk_PPU;
logic n_reset_in;
logic n_reset;
logic req0;
logic req1;
bus_req_t cmd0;
bus_req_t cmd1;
logic req_a [NUM_MASTERS];
bus_req_t cmd_a [NUM_MASTERS];
logic ack_a [NUM_MASTERS];
bus_rsp_t rsp_a [NUM_MASTERS];
logic [7:0] x;
logic [7:0] y;
logic [23:0] rgb;

logic [31:0] lfsr_state = 32'ha3eee0b3;
logic [7:0] model [65536];
int errors = 0;
int monitor_errors = 0;
int tests_passed = 0;
int tests_failed = 0;
int y_wraps = 0;
int grants[$];

assign req_a[0] = req0;
assign req_a[1] = req1;
assign cmd_a[0] = cmd0;
assign cmd_a[1] = cmd1;

tb_clock u_clock (
	.clk_PPU(clk_PPU),
	.n_reset_in(n_reset_in)
);

system u_dut (
	.clk_PPU(clk_PPU),
	.n_reset_in(n_reset_in),
	.n_reset(n_reset),
	.req(req_a),
	.cmd(cmd_a),
	.ack(ack_a),
	.rsp(rsp_a),
	.x(x),
	.y(y),
	.rgb(rgb)
);

// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	logic fb;
	r = '0;
	for (int i = 0; i < n; i++) begin
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		r = {r[30:0], fb};
	end
	return r;
endfunction

// Model index, work RAM folds onto its first 2 kB
function automatic logic [15:0] model_addr(input logic [15:0] addr);
	if (addr < 16'h2000)
		return {5'b0, addr[10:0]};
	return addr;
endfunction

// Expected answer from the memory map
function automatic bus_rsp_t expected(input logic [15:0] addr);
	bus_rsp_t e;
	e.err = 1'b0;
	if (addr < 16'h2000 || (addr >= 16'h6000 && addr < 16'h8000))
		e.rdata = model[model_addr(addr)];
	else if (addr >= 16'h8000)
		e.rdata = (addr[14:0] < 15'd32) ? (addr[7:0] ^ 8'h5a) : 8'h00;
	else begin
		e.rdata = 8'hff;
		e.err = 1'b1;
	end
	return e;
endfunction

task automatic drive(input int port, input logic r, input bus_req_t c);
	if (port == 0) begin
		req0 <= r;
		cmd0 <= c;
	end else begin
		req1 <= r;
		cmd1 <= c;
	end
endtask

// One four-phase transaction, latency checked only when the bus is free
task automatic transact(input int port, input logic [15:0] addr, input logic we,
		input logic [7:0] wdata, input bit solo, output bus_rsp_t r);
	int n;
	bus_req_t c;
	c = '{addr: addr, we: we, wdata: wdata};
	@(posedge clk_PPU);
	drive(port, 1'b1, c);
	n = 0;
	do begin
		@(posedge clk_PPU);
		#1;
		n++;
	end while (!ack_a[port] && n < TIMEOUT);
	if (!ack_a[port]) begin
		$display("Port %0d got no ack for address %h", port, addr);
		errors++;
	end else if (solo) begin
		assert (n - 1 == 4) else begin
			$display("Mismatch ack_rise_cycles: got %h expected %h", n - 1, 4);
			errors++;
		end
	end
	r = rsp_a[port];
	@(posedge clk_PPU);
	drive(port, 1'b0, c);
	n = 0;
	do begin
		@(posedge clk_PPU);
		#1;
		n++;
	end while (ack_a[port] && n < TIMEOUT);
	if (ack_a[port]) begin
		$display("Port %0d kept ack high after req fell", port);
		errors++;
	end else begin
		assert (n == 2) else begin
			$display("Mismatch ack_fall_cycles: got %h expected %h", n, 2);
			errors++;
		end
	end
endtask

task automatic compare_rsp(input logic [15:0] addr, input bus_rsp_t got);
	bus_rsp_t e;
	e = expected(addr);
	assert (got.rdata == e.rdata) else begin
		$display("Mismatch rdata at %h: got %h expected %h", addr, got.rdata, e.rdata);
		errors++;
	end
	assert (got.err == e.err) else begin
		$display("Mismatch err at %h: got %h expected %h", addr, got.err, e.err);
		errors++;
	end
endtask

task automatic access(input int port, input logic [15:0] addr, input logic we,
		input logic [7:0] wdata);
	bus_rsp_t r;
	transact(port, addr, we, wdata, 1'b1, r);
	if (we && (addr < 16'h2000 || (addr >= 16'h6000 && addr < 16'h8000)))
		model[model_addr(addr)] = wdata;
	compare_rsp(addr, r);
endtask

task automatic end_test(input string name, input int start_errors);
	int n;
	n = errors + monitor_errors - start_errors;
	if (n == 0)
		tests_passed++;
	else
		tests_failed++;
	$display("%s: %s (%0d errors)", name, (n == 0) ? "pass" : "FAIL", n);
endtask

// Bus exclusivity, grant order and raster pattern
always @(negedge clk_PPU) begin
	logic [7:0] px;
	logic [7:0] py;
	logic [7:0] ey;
	logic have_prev;
	logic [1:0] ack_prev;
	if (!n_reset) begin
		have_prev = 1'b0;
		ack_prev = 2'b00;
	end else begin
		assert (!(ack_a[0] && ack_a[1])) else begin
			$display("Both masters saw ack at the same time");
			monitor_errors++;
		end
		for (int i = 0; i < 2; i++)
			if (ack_a[i] && !ack_prev[i])
				grants.push_back(i);
		ack_prev = {ack_a[1], ack_a[0]};
		if (have_prev) begin
			assert (rgb[7:0] == x) else begin
				$display("Mismatch rgb_low: got %h expected %h", rgb[7:0], x);
				monitor_errors++;
			end
			if (px == 8'd255) begin
				ey = (py == 8'd239) ? 8'd0 : py + 8'd1;
				if (py == 8'd239)
					y_wraps++;
				assert (x == 8'd0 && y == ey) else begin
					$display("Mismatch y: got %h expected %h", y, ey);
					monitor_errors++;
				end
			end else begin
				assert (x == px + 8'd1 && y == py) else begin
					$display("Mismatch x: got %h expected %h", x, px + 8'd1);
					monitor_errors++;
				end
			end
		end
		have_prev = 1'b1;
		px = x;
		py = y;
	end
end

initial begin
	int start;
	int n;
	logic [31:0] r;
	logic [15:0] a;
	logic [7:0] d;
	logic [1:0] mirror;
	bus_rsp_t got0;
	bus_rsp_t got1;
	req0 = 1'b0;
	req1 = 1'b0;
	cmd0 = '0;
	cmd1 = '0;

	// Reset lasts its input cycles plus the two release flops
	start = errors + monitor_errors;
	n = 0;
	do begin
		@(posedge clk_PPU);
		#1;
		n++;
	end while (!n_reset && n < TIMEOUT);
	if (!n_reset) begin
		$display("Reset never released");
		errors++;
	end else begin
		assert (n == RESET_CYCLES + 2) else begin
			$display("Mismatch n_reset_release_cycles: got %h expected %h",
				n, RESET_CYCLES + 2);
			errors++;
		end
	end
	assert (x == 8'd0 && y == 8'd0 && rgb == 24'd0) else begin
		$display("Mismatch video_reset: got %h %h %h expected 0", x, y, rgb);
		errors++;
	end
	end_test("reset", start);

	// Write then read back, RAM through a different mirror
	start = errors + monitor_errors;
	for (int i = 0; i < 8; i++) begin
		r = rand_bits(21);
		a = {3'b000, r[12:0]};
		d = r[20:13];
		access(i % 2, a, 1'b1, d);
		r = rand_bits(2);
		mirror = (r[1:0] == 2'b00) ? 2'b01 : r[1:0];
		access((i + 1) % 2, a ^ {3'b000, mirror, 11'd0}, 1'b0, 8'h00);
		r = rand_bits(21);
		a = {3'b011, r[12:0]};
		access(i % 2, a, 1'b1, r[20:13]);
		access((i + 1) % 2, a, 1'b0, 8'h00);
	end
	end_test("ram_sram", start);

	start = errors + monitor_errors;
	for (int i = 0; i < 32; i++)
		access(i % 2, 16'h8000 + 16'(i), 1'b0, 8'h00);
	for (int i = 0; i < 4; i++) begin
		r = rand_bits(15);
		a = {1'b1, r[14:0] | 15'h0020};
		access(i % 2, a, 1'b0, 8'h00);
	end
	r = rand_bits(13);
	a = {11'b1000_0000_000, r[4:0]};
	access(0, a, 1'b1, r[12:5]);
	access(1, a, 1'b0, 8'h00);
	end_test("rom", start);

	start = errors + monitor_errors;
	for (int i = 0; i < 6; i++) begin
		r = rand_bits(14);
		a = {(r[13] ? 3'b010 : 3'b001), r[12:0]};
		access(i % 2, a, i[0], 8'h3c);
	end
	end_test("unmapped", start);

	// Port 0 wins alone first, then both masters request together each round
	start = errors + monitor_errors;
	grants.delete();
	access(0, 16'h8000, 1'b0, 8'h00);
	for (int k = 0; k < ROUNDS; k++) begin
		fork
			begin
				transact(0, 16'h8000 + 16'(k), 1'b0, 8'h00, 1'b0, got0);
				compare_rsp(16'h8000 + 16'(k), got0);
			end
			begin
				transact(1, 16'h8010 + 16'(k), 1'b0, 8'h00, 1'b0, got1);
				compare_rsp(16'h8010 + 16'(k), got1);
			end
		join
	end
	if (grants.size() != 2 * ROUNDS + 1) begin
		$display("Expected %0d grants but saw %0d", 2 * ROUNDS + 1, grants.size());
		errors++;
	end
	for (int i = 1; i < grants.size(); i++)
		assert (grants[i] != grants[i - 1]) else begin
			$display("Grant %0d went to port %0d twice in a row", i, grants[i]);
			errors++;
		end
	end_test("round_robin", start);

	// Run until the raster has wrapped once
	start = errors + monitor_errors;
	n = 0;
	while (y_wraps == 0 && n < 70000) begin
		@(posedge clk_PPU);
		n++;
	end
	if (y_wraps == 0) begin
		$display("Raster never wrapped to the first line");
		errors++;
	end
	end_test("video_raster", start);

	$display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
	if (tests_failed == 0 && errors + monitor_errors == 0)
		$display("All tests passed");
	else
		$display("Some tests failed");
	$finish;
end

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clk_PPU,
	output logic n_reset_in
);

// 4 ns period, reset low for the first 8 cycles
initial begin
	clk_PPU = 1'b0;
	n_reset_in = 1'b0;
	repeat (16) #2 clk_PPU = ~clk_PPU;
	n_reset_in = 1'b1;
	forever #2 clk_PPU = ~clk_PPU;
end

endmodule

// ==== logic/system.sv ====
`timescale 1ns/1ps

module system import sys_pkg::*; (
	input  logic        clk_PPU,
	input  logic        n_reset_in,
	output logic        n_reset,
	// Master ports, 0 is the CPU and 1 the audio DMA
	input  logic        req [NUM_MASTERS],
	input  bus_req_t    cmd [NUM_MASTERS],
	output logic        ack [NUM_MASTERS],
	output bus_rsp_t    rsp [NUM_MASTERS],
	// Video
	output logic [7:0]  x,
	output logic [7:0]  y,
	output logic [23:0] rgb
);

logic rst_meta;
logic mem_start;
logic mem_done;
bus_req_t mem_cmd;
bus_rsp_t mem_rsp;

// Reset reformation, async assert and two-stage release
always_ff @(posedge clk_PPU, negedge n_reset_in)
	if (~n_reset_in) begin
		rst_meta <= 1'b0;
		n_reset <= 1'b0;
	end else begin
		rst_meta <= 1'b1;
		n_reset <= rst_meta;
	end

bus_arbiter #(.N(NUM_MASTERS)) u_arbiter (
	.clk_PPU(clk_PPU),
	.n_reset(n_reset),
	.req(req),
	.cmd(cmd),
	.ack(ack),
	.rsp(rsp),
	.mem_start(mem_start),
	.mem_cmd(mem_cmd),
	.mem_done(mem_done),
	.mem_rsp(mem_rsp)
);

mem_decoder u_decoder (
	.clk_PPU(clk_PPU),
	.n_reset(n_reset),
	.mem_start(mem_start),
	.mem_cmd(mem_cmd),
	.mem_done(mem_done),
	.mem_rsp(mem_rsp)
);

video_pattern u_video (
	.clk_PPU(clk_PPU),
	.n_reset(n_reset),
	.x(x),
	.y(y),
	.rgb(rgb)
);

endmodule

// ==== logic/video_pattern.sv ====
`timescale 1ns/1ps

module video_pattern import sys_pkg::*; (
	input  logic        clk_PPU,
	input  logic        n_reset,
	output logic [7:0]  x,
	output logic [7:0]  y,
	output logic [23:0] rgb
);

// Raster position
always_ff @(posedge clk_PPU, negedge n_reset)
	if (~n_reset) begin
		x <= 8'd0;
		y <= 8'd0;
	end else begin
		if (x == X_LAST) begin
			x <= 8'd0;
			// New line, wrap at the bottom
			if (y == Y_LAST)
				y <= 8'd0;
			else
				y <= y + 8'd1;
		end else begin
			x <= x + 8'd1;
		end
	end

// Test colour, one step per pixel
always_ff @(posedge clk_PPU, negedge n_reset)
	if (~n_reset)
		rgb <= 24'h0;
	else
		rgb <= rgb + 24'h1;

endmodule

// ==== logic/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter import sys_pkg::*; #(
	parameter int N = 2
) (
	input  logic     clk_PPU,
	input  logic     n_reset,
	input  logic     req [N],
	input  bus_req_t cmd [N],
	output logic     ack [N],
	output bus_rsp_t rsp [N],
	output logic     mem_start,
	output bus_req_t mem_cmd,
	input  logic     mem_done,
	input  bus_rsp_t mem_rsp
);

localparam int IW = (N > 1) ? $clog2(N) : 1;

typedef enum logic [2:0] {
	ST_IDLE,
	ST_ISSUE,
	ST_WAIT,
	ST_HOLD,
	ST_RELEASE
} state_e;

state_e state;
// Last winner, which is also the owner during a transaction
logic [IW-1:0] last;
logic [IW-1:0] pick;
logic any_req;
logic [N-1:0] ack_q;

// Round-robin search starting just after the last winner
always_comb begin
	int idx;
	any_req = 1'b0;
	pick = last;
	for (int k = 1; k <= N; k++) begin
		idx = (int'(last) + k) % N;
		if (req[idx] && !any_req) begin
			any_req = 1'b1;
			pick = IW'(idx);
		end
	end
end

always_ff @(posedge clk_PPU, negedge n_reset)
	if (~n_reset) begin
		state <= ST_IDLE;
		// Master 0 comes first after reset
		last <= IW'(N - 1);
		mem_start <= 1'b0;
		ack_q <= '0;
	end else begin
		mem_start <= 1'b0;
		case (state)
			ST_IDLE:
				if (any_req) begin
					last <= pick;
					state <= ST_ISSUE;
				end
			ST_ISSUE: begin
				mem_start <= 1'b1;
				state <= ST_WAIT;
			end
			ST_WAIT:
				if (mem_done) begin
					ack_q[last] <= 1'b1;
					state <= ST_HOLD;
				end
			// Owner keeps the bus until it drops req
			ST_HOLD:
				if (!req[last])
					state <= ST_RELEASE;
			ST_RELEASE: begin
				ack_q <= '0;
				state <= ST_IDLE;
			end
			default: state <= ST_IDLE;
		endcase
	end

// Command and response latches
always_ff @(posedge clk_PPU) begin
	if (state == ST_IDLE && any_req)
		mem_cmd <= cmd[pick];
	if (state == ST_WAIT && mem_done)
		rsp[last] <= mem_rsp;
end

genvar i;
generate
	for (i = 0; i < N; i++) begin: gen_ack
		assign ack[i] = ack_q[i];
	end
endgenerate

a_ack_onehot: assert property (@(posedge clk_PPU) disable iff (~n_reset)
	$onehot0(ack_q));

// Decoder latency must land inside the wait state
a_done_in_wait: assert property (@(posedge clk_PPU) disable iff (~n_reset)
	mem_done |-> state == ST_WAIT);

endmodule

// ==== logic/mem_decoder.sv ====
`timescale 1ns/1ps

module mem_decoder import sys_pkg::*; (
	input  logic     clk_PPU,
	input  logic     n_reset,
	input  logic     mem_start,
	input  bus_req_t mem_cmd,
	output logic     mem_done,
	output bus_rsp_t mem_rsp
);

localparam int RAM_AW  = $clog2(RAM_WORDS);
localparam int SRAM_AW = $clog2(SRAM_WORDS);
localparam int ROM_AW  = $clog2(ROM_WORDS);

region_e region;
region_e region_q;
logic ram_we;
logic sram_we;
logic busy;
logic [7:0] ram_q;
logic [7:0] sram_q;
logic [7:0] rom_q;

// Address decode, RAM mirrors through the low 11 bits
always_comb begin
	if (mem_cmd.addr[15:13] == RAM_BASE[15:13])
		region = REG_RAM;
	else if (mem_cmd.addr[15:13] == SRAM_BASE[15:13])
		region = REG_SRAM;
	else if (mem_cmd.addr[15] == ROM_BASE[15])
		region = REG_ROM;
	else
		region = REG_NONE;
end

// No write path to the ROM
assign ram_we  = mem_start & mem_cmd.we & (region == REG_RAM);
assign sram_we = mem_start & mem_cmd.we & (region == REG_SRAM);

sync_ram #(.WORDS(RAM_WORDS)) u_work_ram (
	.clk_PPU(clk_PPU),
	.addr(mem_cmd.addr[RAM_AW-1:0]),
	.wdata(mem_cmd.wdata),
	.we(ram_we),
	.rdata(ram_q)
);

sync_ram #(.WORDS(SRAM_WORDS)) u_cart_sram (
	.clk_PPU(clk_PPU),
	.addr(mem_cmd.addr[SRAM_AW-1:0]),
	.wdata(mem_cmd.wdata),
	.we(sram_we),
	.rdata(sram_q)
);

boot_rom u_boot_rom (
	.clk_PPU(clk_PPU),
	.addr(mem_cmd.addr[ROM_AW-1:0]),
	.rdata(rom_q)
);

// Two-stage pipeline: memory access, then response
always_ff @(posedge clk_PPU, negedge n_reset)
	if (~n_reset) begin
		busy <= 1'b0;
		mem_done <= 1'b0;
	end else begin
		busy <= mem_start;
		mem_done <= busy;
	end

always_ff @(posedge clk_PPU) begin
	if (mem_start)
		region_q <= region;
	if (busy)
		case (region_q)
			REG_RAM:  mem_rsp <= '{rdata: ram_q, err: 1'b0};
			REG_SRAM: mem_rsp <= '{rdata: sram_q, err: 1'b0};
			REG_ROM:  mem_rsp <= '{rdata: rom_q, err: 1'b0};
			default:  mem_rsp <= '{rdata: 8'hff, err: 1'b1};
		endcase
end

a_one_we: assert property (@(posedge clk_PPU) disable iff (~n_reset)
	$onehot0({ram_we, sram_we}));

endmodule

// ==== logic/boot_rom.sv ====
`timescale 1ns/1ps

module boot_rom import sys_pkg::*; (
	input  logic        clk_PPU,
	input  logic [14:0] addr,
	output logic [7:0]  rdata
);

logic [7:0] mem [ROM_WORDS];

// Image covers the start of the ROM only
initial begin
	for (int i = 0; i < ROM_WORDS; i++)
		mem[i] = 8'h00;
	$readmemh("boot.hex", mem);
end

always_ff @(posedge clk_PPU)
	rdata <= mem[addr];

endmodule

// ==== logic/sync_ram.sv ====
`timescale 1ns/1ps

module sync_ram #(
	parameter int WORDS = 2048
) (
	input  logic                     clk_PPU,
	input  logic [$clog2(WORDS)-1:0] addr,
	input  logic [7:0]               wdata,
	input  logic                     we,
	output logic [7:0]               rdata
);

logic [7:0] mem [WORDS];

// Registered read, new data shows on a write
always_ff @(posedge clk_PPU) begin
	if (we) begin
		mem[addr] <= wdata;
		rdata <= wdata;
	end else begin
		rdata <= mem[addr];
	end
end

endmodule

// ==== logic/sys_pkg.sv ====
package sys_pkg;

	// Payload of one master transaction
	typedef struct packed {
		logic [15:0] addr;
		logic        we;
		logic [7:0]  wdata;
	} bus_req_t;

	// Answer returned to the master
	typedef struct packed {
		logic [7:0] rdata;
		// Set for an unmapped address
		logic       err;
	} bus_rsp_t;

	typedef enum logic [1:0] {
		REG_RAM,
		REG_SRAM,
		REG_ROM,
		REG_NONE
	} region_e;

	// Region bases
	// Work RAM mirrors every 2 kB up to $1FFF
	parameter logic [15:0] RAM_BASE  = 16'h0000;
	parameter logic [15:0] SRAM_BASE = 16'h6000;
	parameter logic [15:0] ROM_BASE  = 16'h8000;

	// Region sizes in bytes
	parameter int RAM_WORDS  = 2048;
	parameter int SRAM_WORDS = 8192;
	parameter int ROM_WORDS  = 32768;

	// Raster limits, both inclusive
	parameter logic [7:0] X_LAST = 8'd255;
	parameter logic [7:0] Y_LAST = 8'd239;

	// CPU on port 0, audio DMA on port 1
	parameter int NUM_MASTERS = 2;

endpackage
